//--- common/fpa_config.svh
// fpa widths and segments
`ifndef FPA_CONFIG_SVH
`define FPA_CONFIG_SVH

// bit 0 is the msb everywhere

// mantissa width, bits 0..39
`define FPA_MANT_W 40

// zp bus and w bus width
`define FPA_ZP_W 16

// external d byte on the low half of zp
`define FPA_D_W 8

// first bit of the middle adder segment
`define FPA_SEG_A 16

// first bit of the low adder segment
`define FPA_SEG_B 32

`endif

//--- common/fpa_data_pkg.sv
// fpa data word types
`include "fpa_config.svh"

package fpa_data_pkg;

	// plain mantissa word with bit 0 as msb
	typedef logic [0:`FPA_MANT_W-1] mant_t;

	// guard bit at -1 followed by the mantissa
	typedef logic [-1:`FPA_MANT_W-1] ext_t;

	// k bus sources in lkb/f9 select order
	typedef enum logic [1:0] {
		k_sum = 2'b00,
		k_m = 2'b01,
		// w in 0..15 and 16..31 with the top byte of w in 32..39
		k_w_rep = 2'b10,
		k_zero = 2'b11
	} kbus_sel_e;

	// zp bus sources
	typedef enum logic [1:0] {
		zp_t_hi = 2'b00,
		zp_t_mid = 2'b01,
		// t 32..39 then d
		zp_t_lo_d = 2'b10,
		zp_flags = 2'b11
	} zp_sel_e;

	// cpu condition flags
	typedef struct packed {
		logic z;
		logic m;
		logic v;
		logic c;
	} flags_t;

	// zp word read as a t slice or as the flags layout
	typedef union packed {
		logic [0:`FPA_ZP_W-1] data;
		struct packed {
			flags_t flags;
			// always zero
			logic [0:`FPA_ZP_W-5] rsvd;
		} flg;
	} zp_word_u;

endpackage

//--- common/fpa_ctrl_pkg.sv
// fpa control and status types
package fpa_ctrl_pkg;

	// t register ops
	typedef enum logic [1:0] {
		t_hold = 2'b00,
		t_load_k = 2'b01,
		t_shl = 2'b10,
		t_shr = 2'b11
	} t_op_e;

	// m register ops
	typedef enum logic [1:0] {
		m_hold = 2'b00,
		m_load_t = 2'b01,
		m_shl = 2'b10,
		m_shr = 2'b11
	} m_op_e;

	// adder operand forms
	typedef enum logic [1:0] {
		// t + c
		alu_add = 2'b00,
		// t + ~c + 1
		alu_sub = 2'b01,
		alu_pass_t = 2'b10,
		alu_pass_c = 2'b11
	} alu_op_e;

	// per-block control slices
	typedef struct packed {
		logic t_clr;
		t_op_e t_op;
		logic t_1_d;
		fpa_data_pkg::kbus_sel_e k_sel;
	} t_ctrl_t;

	typedef struct packed {
		logic m_clr;
		m_op_e m_op;
		logic m_1_d;
	} m_ctrl_t;

	typedef struct packed {
		logic c_load;
		logic c_shr;
		alu_op_e alu_op;
	} alu_ctrl_t;

	typedef struct packed {
		logic zp_clr;
		fpa_data_pkg::zp_sel_e zp_sel;
	} zp_ctrl_t;

	// all strobes for one cycle
	typedef struct packed {
		t_ctrl_t t;
		m_ctrl_t m;
		alu_ctrl_t alu;
		zp_ctrl_t zp;
	} fpa_ctrl_t;

	// levels for the microsequencer
	typedef struct packed {
		// register taps
		logic t_1;
		logic t0;
		logic t1;
		logic t16;
		logic t39;
		logic m_1;
		logic m0;
		logic m14;
		logic m15;
		logic m32;
		logic m38;
		logic m39;
		logic c0;
		logic c39;
		// high when the group of t is nonzero
		logic z_0_1;
		logic z_2_7;
		logic z_8_15;
		logic z_16_23;
		logic z_24_31;
		logic z_32_39;
		// sign comparisons
		logic c0_eq_c1;
		logic t0_eq_c0;
		logic t0_neq_t1;
		logic t0_neq_t_1;
		// segment carries
		logic co0;
		logic co16;
		logic co32;
	} fpa_status_t;

endpackage

//--- fpa/fpa_t_reg.sv
// fpa t register
`timescale 1ns/1ps
`include "fpa_config.svh"

module fpa_t_reg (
	input logic clk_sys,
	input logic arst_n,
	input fpa_ctrl_pkg::t_ctrl_t ctrl,
	input logic [0:`FPA_ZP_W-1] w,
	input fpa_data_pkg::mant_t sum,
	input fpa_data_pkg::ext_t m,
	output fpa_data_pkg::ext_t t
);

	fpa_data_pkg::mant_t k;

	// k bus mux
	always_comb begin
		case (ctrl.k_sel)
			fpa_data_pkg::k_sum: begin
				k = sum;
			end
			fpa_data_pkg::k_m: begin
				// guard bit of m not on the bus
				k = m[0:`FPA_MANT_W-1];
			end
			fpa_data_pkg::k_w_rep: begin
				// two full copies and then the top byte
				k = {w, w, w[0:`FPA_MANT_W-2*`FPA_ZP_W-1]};
			end
			default: begin
				k = '0;
			end
		endcase
	end

	// t register where clear wins over the op
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			t <= '0;
		end else if (ctrl.t_clr) begin
			t <= '0;
		end else begin
			case (ctrl.t_op)
				fpa_ctrl_pkg::t_load_k: begin
					// guard comes from outside
					t <= {ctrl.t_1_d, k};
				end
				fpa_ctrl_pkg::t_shl: begin
					// t0 into guard and m guard into t39
					// t and m act as one long register here
					t <= {t[0:`FPA_MANT_W-1], m[-1]};
				end
				fpa_ctrl_pkg::t_shr: begin
					// guard kept and copied into t0
					t <= {t[-1], t[-1:`FPA_MANT_W-2]};
				end
				default: begin
					t <= t;
				end
			endcase
		end
	end

endmodule

//--- fpa/fpa_m_reg.sv
// fpa m register
`timescale 1ns/1ps
`include "fpa_config.svh"

module fpa_m_reg (
	input logic clk_sys,
	input logic arst_n,
	input fpa_ctrl_pkg::m_ctrl_t ctrl,
	input fpa_data_pkg::ext_t t,
	output fpa_data_pkg::ext_t m
);

	// multiplier / extension register
	// always loaded full width
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			m <= '0;
		end else if (ctrl.m_clr) begin
			m <= '0;
		end else begin
			case (ctrl.m_op)
				fpa_ctrl_pkg::m_load_t: begin
					// t guard dropped, m guard from outside
					m <= {ctrl.m_1_d, t[0:`FPA_MANT_W-1]};
				end
				fpa_ctrl_pkg::m_shl: begin
					// m0 into guard, zero into m39
					m <= {m[0:`FPA_MANT_W-1], 1'b0};
				end
				fpa_ctrl_pkg::m_shr: begin
					// guard kept, m_1_d into m0
					// m39 falls off
					m <= {m[-1], ctrl.m_1_d, m[0:`FPA_MANT_W-2]};
				end
				default: begin
					m <= m;
				end
			endcase
		end
	end

endmodule

//--- fpa/fpa_alu.sv
// fpa c register and mantissa adder
`timescale 1ns/1ps
`include "fpa_config.svh"

module fpa_alu (
	input logic clk_sys,
	input logic arst_n,
	input fpa_ctrl_pkg::alu_ctrl_t ctrl,
	input fpa_data_pkg::mant_t t,
	output fpa_data_pkg::mant_t c,
	output fpa_data_pkg::mant_t sum,
	output logic co0,
	output logic co16,
	output logic co32
);

	// segment widths counted up from bit 39
	localparam int mid_w = `FPA_MANT_W - `FPA_SEG_A;
	localparam int low_w = `FPA_MANT_W - `FPA_SEG_B;

	fpa_data_pkg::mant_t opa;
	fpa_data_pkg::mant_t opb;
	logic cin;
	logic [`FPA_MANT_W:0] full_sum;
	logic [mid_w:0] mid_sum;
	logic [low_w:0] low_sum;

	// c register where load has priority over shift
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			c <= '0;
		end else if (ctrl.c_load) begin
			c <= t;
		end else if (ctrl.c_shr) begin
			// arithmetic shift keeps the sign in c0
			c <= {c[0], c[0:`FPA_MANT_W-2]};
		end
	end

	// operand forming
	always_comb begin
		case (ctrl.alu_op)
			fpa_ctrl_pkg::alu_add: begin
				opa = t;
				opb = c;
				cin = 1'b0;
			end
			fpa_ctrl_pkg::alu_sub: begin
				// two's complement of c
				opa = t;
				opb = ~c;
				cin = 1'b1;
			end
			fpa_ctrl_pkg::alu_pass_t: begin
				opa = t;
				opb = '0;
				cin = 1'b0;
			end
			default: begin
				opa = '0;
				opb = c;
				cin = 1'b0;
			end
		endcase
	end

	// one sum per segment from the same carry-in
	// segment sums only deliver their carry
	always_comb begin
		full_sum = {1'b0, opa} + {1'b0, opb} + cin;
		mid_sum = {1'b0, opa[`FPA_SEG_A:`FPA_MANT_W-1]}
			+ {1'b0, opb[`FPA_SEG_A:`FPA_MANT_W-1]} + cin;
		low_sum = {1'b0, opa[`FPA_SEG_B:`FPA_MANT_W-1]}
			+ {1'b0, opb[`FPA_SEG_B:`FPA_MANT_W-1]} + cin;
	end

	// top result bit lands in sum bit 0
	assign sum = full_sum[`FPA_MANT_W-1:0];
	// carry out above bit 0
	assign co0 = full_sum[`FPA_MANT_W];
	// out of 16..39
	assign co16 = mid_sum[mid_w];
	// out of 32..39
	assign co32 = low_sum[low_w];

endmodule

//--- fpa/fpa_status.sv
// fpa zp bus and status levels
`timescale 1ns/1ps
`include "fpa_config.svh"

module fpa_status (
	input fpa_data_pkg::ext_t t,
	input fpa_data_pkg::ext_t m,
	input fpa_data_pkg::mant_t c,
	input logic co0,
	input logic co16,
	input logic co32,
	input logic [0:`FPA_D_W-1] d,
	input fpa_data_pkg::flags_t flags,
	input fpa_ctrl_pkg::zp_ctrl_t ctrl,
	output fpa_data_pkg::zp_word_u zp,
	output fpa_ctrl_pkg::fpa_status_t status
);

	// zp mux gives a cleared word unless a source is picked
	always_comb begin
		zp = '0;
		if (!ctrl.zp_clr) begin
			case (ctrl.zp_sel)
				fpa_data_pkg::zp_t_hi: begin
					zp.data = t[0:`FPA_SEG_A-1];
				end
				fpa_data_pkg::zp_t_mid: begin
					zp.data = t[`FPA_SEG_A:`FPA_SEG_B-1];
				end
				fpa_data_pkg::zp_t_lo_d: begin
					// last t byte then d
					zp.data = {t[`FPA_SEG_B:`FPA_MANT_W-1], d};
				end
				default: begin
					// flags on top and the rest reads zero
					zp.flg.flags = flags;
					zp.flg.rsvd = '0;
				end
			endcase
		end
	end

	always_comb begin
		// taps
		status.t_1 = t[-1];
		status.t0 = t[0];
		status.t1 = t[1];
		status.t16 = t[16];
		status.t39 = t[39];
		status.m_1 = m[-1];
		status.m0 = m[0];
		status.m14 = m[14];
		status.m15 = m[15];
		status.m32 = m[32];
		status.m38 = m[38];
		status.m39 = m[39];
		status.c0 = c[0];
		status.c39 = c[39];
		// zero groups set on any one bit
		status.z_0_1 = |t[0:1];
		status.z_2_7 = |t[2:7];
		status.z_8_15 = |t[8:15];
		status.z_16_23 = |t[16:23];
		status.z_24_31 = |t[24:31];
		status.z_32_39 = |t[32:39];
		// sign checks for normalise and overflow
		status.c0_eq_c1 = c[0] == c[1];
		status.t0_eq_c0 = t[0] == c[0];
		status.t0_neq_t1 = t[0] != t[1];
		status.t0_neq_t_1 = t[0] != t[-1];
		// adder carries passed through
		status.co0 = co0;
		status.co16 = co16;
		status.co32 = co32;
	end

endmodule

//--- verilog/fpa_top.sv
// fpa mantissa unit top
`timescale 1ns/1ps
`include "fpa_config.svh"

module fpa_top (
	input logic clk_sys,
	input logic arst_n,
	input fpa_ctrl_pkg::fpa_ctrl_t ctrl,
	input logic [0:`FPA_ZP_W-1] w,
	input logic [0:`FPA_D_W-1] d,
	input fpa_data_pkg::flags_t flags,
	output fpa_data_pkg::zp_word_u zp,
	output fpa_ctrl_pkg::fpa_status_t status
);

	fpa_data_pkg::ext_t t;
	fpa_data_pkg::ext_t m;
	fpa_data_pkg::mant_t c;
	fpa_data_pkg::mant_t sum;
	logic co0;
	logic co16;
	logic co32;

	// t takes sum and m on the k bus
	fpa_t_reg i_t_reg (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.ctrl(ctrl.t),
		.w(w),
		.sum(sum),
		.m(m),
		.t(t)
	);

	fpa_m_reg i_m_reg (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.ctrl(ctrl.m),
		.t(t),
		.m(m)
	);

	// adder sees t without its guard
	fpa_alu i_alu (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.ctrl(ctrl.alu),
		.t(t[0:`FPA_MANT_W-1]),
		.c(c),
		.sum(sum),
		.co0(co0),
		.co16(co16),
		.co32(co32)
	);

	fpa_status i_status (
		.t(t),
		.m(m),
		.c(c),
		.co0(co0),
		.co16(co16),
		.co32(co32),
		.d(d),
		.flags(flags),
		.ctrl(ctrl.zp),
		.zp(zp),
		.status(status)
	);

endmodule

//--- dv/fpa_assert.sv
// fpa top level assertions
`timescale 1ns/1ps
`include "fpa_config.svh"

module fpa_assert (
	input logic clk_sys,
	input logic arst_n,
	input fpa_ctrl_pkg::fpa_ctrl_t ctrl,
	input fpa_data_pkg::zp_word_u zp,
	input fpa_data_pkg::ext_t t,
	input fpa_data_pkg::mant_t c
);

	// clear empties t, guard included, one edge later
	property t_clr_zero;
		@(posedge clk_sys) disable iff (!arst_n)
			ctrl.t.t_clr |=> (t == '0);
	endproperty

	// zp clear beats any select
	property zp_clr_zero;
		@(posedge clk_sys) disable iff (!arst_n)
			ctrl.zp.zp_clr |-> (zp.data == '0);
	endproperty

	// parallel load copies t without its guard
	property c_load_copy;
		@(posedge clk_sys) disable iff (!arst_n)
			ctrl.alu.c_load |=> (c == $past(t[0:`FPA_MANT_W-1]));
	endproperty

	assert property (t_clr_zero) else $error("t not zero after t_clr");
	assert property (zp_clr_zero) else $error("zp not zero under zp_clr");
	assert property (c_load_copy) else $error("c differs from previous t after c_load");

endmodule

bind fpa_top fpa_assert i_fpa_assert (
	.clk_sys(clk_sys),
	.arst_n(arst_n),
	.ctrl(ctrl),
	.zp(zp),
	.t(t),
	.c(c)
);

//--- dv/fpa_tb.sv
// fpa mantissa unit testbench
`timescale 1ns/1ps
`include "fpa_config.svh"

module fpa_tb;

	logic clk_sys;
	logic arst_n;
	fpa_ctrl_pkg::fpa_ctrl_t ctrl;
	logic [0:`FPA_ZP_W-1] w;
	logic [0:`FPA_D_W-1] d;
	fpa_data_pkg::flags_t flags;
	fpa_data_pkg::zp_word_u zp;
	fpa_ctrl_pkg::fpa_status_t status;

	// model registers
	fpa_data_pkg::ext_t mt;
	fpa_data_pkg::ext_t mm;
	fpa_data_pkg::mant_t mc;
	// expected combinational values for this cycle
	fpa_data_pkg::mant_t esum;
	logic [0:`FPA_ZP_W-1] ezp;
	fpa_ctrl_pkg::fpa_status_t est;
	int errors;
	int tests_run;
	int tests_failed;

	fpa_top i_dut (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.ctrl(ctrl),
		.w(w),
		.d(d),
		.flags(flags),
		.zp(zp),
		.status(status)
	);

	initial begin
		clk_sys = 1'b0;
		forever begin
			#5 clk_sys = ~clk_sys;
		end
	end

	// hard stop if a test never returns
	initial begin
		for (int i = 0; i < 20000; i++) begin
			#10;
		end
		$display("timeout: simulation ran past its time limit");
		$display("Testbench failed");
		$finish;
	end

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp) else begin
			$display("FAILED %0t %s got %0h expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	// random inputs, then nudged toward what the test exercises
	task automatic drive_inputs(input int mode);
		logic [31:0] rnd;
		logic [31:0] bias;
		rnd = $urandom;
		bias = $urandom;
		ctrl = rnd[$bits(fpa_ctrl_pkg::fpa_ctrl_t)-1:0];
		rnd = $urandom;
		w = rnd[15:0];
		d = rnd[23:16];
		flags = rnd[27:24];
		// clears stay rare
		ctrl.t.t_clr = bias[3:0] == 4'd0;
		ctrl.m.m_clr = bias[7:4] == 4'd0;
		ctrl.zp.zp_clr = bias[10:8] == 3'd0;
		case (mode)
			0: begin
				// clear everything, read only data selects
				ctrl.t.t_clr = 1'b1;
				ctrl.m.m_clr = 1'b1;
				ctrl.alu.c_load = 1'b1;
				ctrl.zp.zp_clr = 1'b0;
				if (ctrl.zp.zp_sel == fpa_data_pkg::zp_flags) begin
					ctrl.zp.zp_sel = fpa_data_pkg::zp_t_hi;
				end
			end
			1: begin
				ctrl.t.t_clr = 1'b0;
				ctrl.t.t_op = fpa_ctrl_pkg::t_load_k;
			end
			2: begin
				ctrl.t.t_op = bias[11] ? fpa_ctrl_pkg::t_shl : fpa_ctrl_pkg::t_shr;
				ctrl.m.m_op = bias[12] ? fpa_ctrl_pkg::m_shl : fpa_ctrl_pkg::m_shr;
				ctrl.alu.c_load = bias[15:13] == 3'd0;
				ctrl.alu.c_shr = 1'b1;
				// occasional refill so shifts see fresh bits
				if (bias[18:16] == 3'd0) begin
					ctrl.t.t_op = fpa_ctrl_pkg::t_load_k;
				end
				if (bias[21:19] == 3'd0) begin
					ctrl.m.m_op = fpa_ctrl_pkg::m_load_t;
				end
			end
			3: begin
				ctrl.t.t_op = bias[11] ? fpa_ctrl_pkg::t_load_k : fpa_ctrl_pkg::t_hold;
				ctrl.alu.c_load = bias[12];
			end
			4: begin
				ctrl.zp.zp_clr = bias[13:12] == 2'd0;
			end
			default: begin
			end
		endcase
	endtask

	// expected sum, carries, zp and status from the model
	task automatic predict();
		fpa_data_pkg::mant_t a;
		fpa_data_pkg::mant_t b;
		logic ci;
		logic [0:`FPA_MANT_W] s;
		logic [0:`FPA_MANT_W-`FPA_SEG_A] s16;
		logic [0:`FPA_MANT_W-`FPA_SEG_B] s32;
		a = (ctrl.alu.alu_op == fpa_ctrl_pkg::alu_pass_c) ? '0 : mt[0:`FPA_MANT_W-1];
		b = (ctrl.alu.alu_op == fpa_ctrl_pkg::alu_sub) ? ~mc
			: (ctrl.alu.alu_op == fpa_ctrl_pkg::alu_pass_t) ? '0 : mc;
		ci = ctrl.alu.alu_op == fpa_ctrl_pkg::alu_sub;
		s = {1'b0, a} + {1'b0, b} + {40'b0, ci};
		s16 = {1'b0, a[16:39]} + {1'b0, b[16:39]} + {24'b0, ci};
		s32 = {1'b0, a[32:39]} + {1'b0, b[32:39]} + {8'b0, ci};
		esum = s[1:`FPA_MANT_W];
		if (ctrl.zp.zp_clr) begin
			ezp = '0;
		end else begin
			case (ctrl.zp.zp_sel)
				fpa_data_pkg::zp_t_hi: ezp = mt[0:15];
				fpa_data_pkg::zp_t_mid: ezp = mt[16:31];
				fpa_data_pkg::zp_t_lo_d: ezp = {mt[32:39], d};
				default: ezp = {flags, 12'h000};
			endcase
		end
		est = '{
			t_1: mt[-1], t0: mt[0], t1: mt[1], t16: mt[16], t39: mt[39],
			m_1: mm[-1], m0: mm[0], m14: mm[14], m15: mm[15],
			m32: mm[32], m38: mm[38], m39: mm[39], c0: mc[0], c39: mc[39],
			z_0_1: mt[0:1] != '0, z_2_7: mt[2:7] != '0, z_8_15: mt[8:15] != '0,
			z_16_23: mt[16:23] != '0, z_24_31: mt[24:31] != '0,
			z_32_39: mt[32:39] != '0,
			c0_eq_c1: mc[0] == mc[1], t0_eq_c0: mt[0] == mc[0],
			t0_neq_t1: mt[0] != mt[1], t0_neq_t_1: mt[0] != mt[-1],
			co0: s[0], co16: s16[0], co32: s32[0]
		};
	endtask

	// register rules at the rising edge, all from the old values
	task automatic advance();
		fpa_data_pkg::mant_t k;
		fpa_data_pkg::ext_t nt;
		fpa_data_pkg::ext_t nm;
		fpa_data_pkg::mant_t nc;
		case (ctrl.t.k_sel)
			fpa_data_pkg::k_sum: k = esum;
			fpa_data_pkg::k_m: k = mm[0:39];
			fpa_data_pkg::k_w_rep: k = {w, w, w[0:7]};
			default: k = '0;
		endcase
		nt = mt;
		case (ctrl.t.t_op)
			fpa_ctrl_pkg::t_load_k: nt = {ctrl.t.t_1_d, k};
			fpa_ctrl_pkg::t_shl: nt = {mt[0:39], mm[-1]};
			fpa_ctrl_pkg::t_shr: nt = {mt[-1], mt[-1:38]};
			default: nt = mt;
		endcase
		nm = mm;
		case (ctrl.m.m_op)
			fpa_ctrl_pkg::m_load_t: nm = {ctrl.m.m_1_d, mt[0:39]};
			fpa_ctrl_pkg::m_shl: nm = {mm[0:39], 1'b0};
			fpa_ctrl_pkg::m_shr: nm = {mm[-1], ctrl.m.m_1_d, mm[0:38]};
			default: nm = mm;
		endcase
		nc = mc;
		if (ctrl.alu.c_load) begin
			nc = mt[0:39];
		end else if (ctrl.alu.c_shr) begin
			nc = {mc[0], mc[0:38]};
		end
		mt = ctrl.t.t_clr ? '0 : nt;
		mm = ctrl.m.m_clr ? '0 : nm;
		mc = nc;
	endtask

	task automatic run_test(input string name, input int mode, input int cycles);
		int n;
		int err0;
		time deadline;
		err0 = errors;
		n = 0;
		deadline = $time + 10 * (cycles + 20);
		while (n < cycles && $time < deadline) begin
			@(negedge clk_sys);
			drive_inputs(mode);
			// let the combinational outputs settle before the edge
			#2;
			predict();
			check("sum", 64'(i_dut.sum), 64'(esum));
			check("t", 64'(i_dut.t), 64'(mt));
			check("m", 64'(i_dut.m), 64'(mm));
			check("c", 64'(i_dut.c), 64'(mc));
			check("zp", 64'(zp.data), 64'(ezp));
			check("status", 64'(status), 64'(est));
			@(posedge clk_sys);
			advance();
			n++;
		end
		if (n < cycles) begin
			$display("timeout: test %s stopped after %0d of %0d cycles", name, n, cycles);
			errors++;
		end
		tests_run++;
		if (errors != err0) begin
			tests_failed++;
		end
		$display("test %s done, %0d cycles, %0d errors", name, n, errors - err0);
	endtask

	initial begin
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		ctrl = '0;
		w = '0;
		d = '0;
		flags = '0;
		arst_n = 1'b0;
		mt = '0;
		mm = '0;
		mc = '0;
		void'($urandom(32'h8d2115bc));
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		arst_n = 1'b1;
		run_test("reset_clear", 0, 40);
		run_test("kbus_load", 1, 200);
		run_test("shifts", 2, 300);
		run_test("adder", 3, 300);
		run_test("zp_bus", 4, 200);
		run_test("status", 5, 300);
		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

//--- files.f
+incdir+common
common/fpa_data_pkg.sv
common/fpa_ctrl_pkg.sv
fpa/fpa_t_reg.sv
fpa/fpa_m_reg.sv
fpa/fpa_alu.sv
fpa/fpa_status.sv
verilog/fpa_top.sv
dv/fpa_assert.sv
dv/fpa_tb.sv

//--- run.sh
#!/usr/bin/env bash
# verilator build and run of the fpa testbench
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module fpa_tb \
	-f files.f -o fpa_sim > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }
./obj_dir/fpa_sim > sim.log 2>&1 || true
grep -q "^Testbench passed$" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
